// File: source/gpu_mmult_config.svh
// Sizes for the MMULT block; RAM latency must be at least 1 and the address width covers bits 11..2
`default_nettype none

`ifndef GPU_MMULT_CONFIG_SVH
`define GPU_MMULT_CONFIG_SVH

// Register file depth, one 32-bit word per entry
`define GPU_NUM_REGS 32

// Matrix RAM word address width
// Matches byte address bits 11 down to 2 of the host bus
`define GPU_MTX_AWIDTH 10

// Cycles from the first mtx_dover cycle to datack
`define GPU_RAM_LATENCY 2

`endif

`default_nettype wire

// File: source/gpu_mmult_pkg.sv
// Shared MMULT types; field order inside each struct fixes the bit layout on the wires
`default_nettype none

package gpu_mmult_pkg;

	// Opcode of the matrix multiply instruction
	localparam logic [5:0] MMULT_OPCODE = 6'b110110;

	// Host instruction word
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] reg1;
		logic [4:0] reg2;
	} gpu_insn_t;

	// Substituted instruction issued by the sequencer
	// imult  010 0 1 0 src dst
	// imac   010 1 0 0 src dst
	// resmac 010 0 1 1 x   dst
	typedef struct packed {
		logic [2:0] ins_class;
		logic       imac;
		logic       bit11;
		logic       resmac;
		logic [4:0] src;
		logic [4:0] dst;
	} sys_ins_t;

	// Matrix control word, taken from data bits 4..0
	// addw set steps the address by the width instead of by one
	typedef struct packed {
		logic       addw;
		logic [3:0] width;
	} mtx_ctrl_t;

	// Host preload write, shared by register and RAM loads
	typedef struct packed {
		logic [10:0] addr;
		logic [31:0] data;
		logic        wr;
	} host_wr_t;

endpackage

`default_nettype wire

// File: source/systolic_seq.sv
// MMULT sequencer; widths 2..15 only, insn_step must pulse on every cycle mtx_wait is low while active
`include "gpu_mmult_config.svh"
`default_nettype none

module systolic_seq
	import gpu_mmult_pkg::*;
(
	input  wire logic                        sys_clk,
	input  wire logic                        resetl,
	input  wire logic [31:0]                 gpu_din,
	input  wire logic                        mtxcwr,
	input  wire logic                        mtxawr,
	input  wire gpu_insn_t                   instruction,
	input  wire logic                        movei_data,
	input  wire logic                        insn_step,
	input  wire logic                        datack,
	output logic                             mtx_atomic,
	output logic                             mtx_mreq,
	output logic                             mtx_wait,
	output logic [`GPU_MTX_AWIDTH-1:0]       mtxaddr,
	output sys_ins_t                         sysins,
	output logic                             sysser,
	output logic                             multsel
);

	// MMULT decode, only meaningful on a pipeline step
	logic mmult;
	logic mmult_go;

	// One-hot controller flops
	logic st_idle;
	logic st_imult;
	logic st_imac;
	logic st_resmac;
	logic active;

	// Control word and derived address step
	mtx_ctrl_t                   mtx_ctrl;
	logic [`GPU_MTX_AWIDTH-1:0]  addr_step;
	logic                        addr_adv;

	// Remaining multiplies, compared against one for the exit
	logic [3:0] mcount;
	logic       count1;

	// Source register and half select, stepped together
	logic [4:0] sysr1;
	logic       reghalf;
	logic [4:0] sysr2;

	// Read in flight toward the RAM
	logic mtx_dover;

	assign mmult = insn_step & ~movei_data & (instruction.opcode == MMULT_OPCODE);
	// Decodes while busy are dropped
	assign mmult_go = mmult & st_idle;

	assign active = ~st_idle;
	assign sysser = active;
	// Held from the decode step until the sequence drains
	assign mtx_atomic = active | mmult;

	assign count1 = (mcount == 4'h1);

	// Control word and matrix address counter
	assign addr_step = mtx_ctrl.addw ? `GPU_MTX_AWIDTH'(mtx_ctrl.width) : `GPU_MTX_AWIDTH'(1);
	// Advance once per completed read
	assign addr_adv = mtx_dover & datack;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			mtx_ctrl <= '0;
			mtxaddr <= '0;
		end else begin
			if (mtxcwr) begin
				mtx_ctrl <= mtx_ctrl_t'(gpu_din[4:0]);
			end
			// Host write wins over the running count
			if (mtxawr) begin
				mtxaddr <= gpu_din[`GPU_MTX_AWIDTH+1:2];
			end else if (addr_adv) begin
				mtxaddr <= mtxaddr + addr_step;
			end
		end
	end

	// Controller, one state per pipeline step
	// imult, then width-1 imacs, then resmac
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			st_idle <= 1'b1;
			st_imult <= 1'b0;
			st_imac <= 1'b0;
			st_resmac <= 1'b0;
		end else begin
			st_idle <= (st_idle & ~mmult) | (st_resmac & insn_step);
			st_imult <= mmult_go | (st_imult & ~insn_step);
			st_imac <= (st_imult & insn_step) | (st_imac & ~count1) | (st_imac & ~insn_step);
			st_resmac <= (st_imac & count1 & insn_step) | (st_resmac & ~insn_step);
		end
	end

	// Width count and register walk
	// Loaded on decode, stepped with the pipeline
	always_ff @(posedge sys_clk) begin
		if (mmult_go) begin
			mcount <= mtx_ctrl.width;
			{sysr1, reghalf} <= {instruction.reg1, 1'b0};
			sysr2 <= instruction.reg2;
		end else if (insn_step & active) begin
			mcount <= mcount - 4'h1;
			{sysr1, reghalf} <= {sysr1, reghalf} + 6'h1;
		end
	end

	// Half select follows the instruction into the MAC
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			multsel <= 1'b0;
		end else if (insn_step) begin
			multsel <= reghalf & active;
		end
	end

	// Substituted instruction for the current state
	always_comb begin
		sysins.ins_class = 3'b010;
		sysins.imac = st_imac;
		sysins.bit11 = st_imult | st_resmac;
		sysins.resmac = st_resmac;
		sysins.src = sysr1;
		sysins.dst = sysr2;
	end

	// Memory request
	// Level in the fetching states, extended until the read returns
	assign mtx_mreq = st_imult | st_imac | (mtx_dover & ~datack);
	assign mtx_wait = mtx_dover & ~datack;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			mtx_dover <= 1'b0;
		end else begin
			mtx_dover <= mtx_mreq;
		end
	end

endmodule

`default_nettype wire

// File: source/matrix_ram.sv
// Matrix word RAM; one read in flight at a time, host loads must not overlap a running MMULT
`include "gpu_mmult_config.svh"
`default_nettype none

module matrix_ram
	import gpu_mmult_pkg::*;
(
	input  wire logic                        sys_clk,
	input  wire logic                        resetl,
	input  wire host_wr_t                    ram_load,
	input  wire logic                        mtx_mreq,
	input  wire logic [`GPU_MTX_AWIDTH-1:0]  mtxaddr,
	output logic [31:0]                      ram_rdata,
	output logic                             datack
);

	localparam int DEPTH = 2 ** `GPU_MTX_AWIDTH;
	localparam int LAT = `GPU_RAM_LATENCY;
	localparam int CNT_W = $clog2(LAT + 1);

	logic [31:0] mem [DEPTH];

	// Read tracking
	logic             busy;
	logic [CNT_W-1:0] lat_cnt;
	logic             rd_start;

	// New read only once the previous one has been acknowledged
	assign rd_start = mtx_mreq & ~busy;
	// Pulse on the last latency cycle
	assign datack = busy & (lat_cnt == CNT_W'(LAT));

	// Host preload port
	always_ff @(posedge sys_clk) begin
		if (ram_load.wr) begin
			mem[ram_load.addr[`GPU_MTX_AWIDTH-1:0]] <= ram_load.data;
		end
	end

	// Word is fetched at request time and held until the acknowledge
	always_ff @(posedge sys_clk) begin
		if (rd_start) begin
			ram_rdata <= mem[mtxaddr];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			busy <= 1'b0;
			lat_cnt <= '0;
		end else if (rd_start) begin
			busy <= 1'b1;
			lat_cnt <= '0;
		end else if (datack) begin
			busy <= 1'b0;
			lat_cnt <= '0;
		end else if (busy) begin
			lat_cnt <= lat_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/mac_unit.sv
// Register file and MAC; products are signed 16x16, sums wrap at 32 bits, preloads only while idle
`include "gpu_mmult_config.svh"
`default_nettype none

module mac_unit
	import gpu_mmult_pkg::*;
(
	input  wire logic        sys_clk,
	input  wire logic        resetl,
	input  wire host_wr_t    reg_load,
	input  wire sys_ins_t    sysins,
	input  wire logic        sysser,
	input  wire logic        insn_step,
	input  wire logic        multsel,
	input  wire logic        datack,
	input  wire logic [31:0] ram_rdata,
	input  wire logic [4:0]  rd_addr,
	output logic [31:0]      rd_data
);

	logic [31:0] regs [`GPU_NUM_REGS];
	logic [31:0] acc;
	logic [31:0] acc_next;

	// Instruction waiting for its RAM word
	sys_ins_t op_q;
	logic     op_valid;
	logic     op_imult;
	logic     op_imac;

	// Product operands
	logic [31:0]        src_word;
	logic signed [15:0] reg_half;
	logic signed [15:0] ram_half;
	logic signed [31:0] product;

	// Write of the accumulator to the destination
	logic res_wr;

	// Latch on each step of an active sequence
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			op_q <= '0;
		end else if (insn_step & sysser) begin
			op_q <= sysins;
		end
	end

	// Reset value has class 000 so nothing executes before the first step
	assign op_valid = (op_q.ins_class == 3'b010);
	assign op_imult = op_valid & op_q.bit11 & ~op_q.resmac & ~op_q.imac;
	assign op_imac = op_valid & op_q.imac;

	assign src_word = regs[op_q.src];
	assign reg_half = multsel ? src_word[31:16] : src_word[15:0];
	assign ram_half = ram_rdata[15:0];
	assign product = reg_half * ram_half;

	// Accumulator as seen after this cycle
	// A resmac in the same cycle as the last datack still picks up the last product
	always_comb begin
		acc_next = acc;
		if (datack & op_imult) begin
			acc_next = product;
		end else if (datack & op_imac) begin
			acc_next = acc + product;
		end
	end

	always_ff @(posedge sys_clk) begin
		acc <= acc_next;
	end

	// Resmac acts on its own step, not on a RAM answer
	assign res_wr = insn_step & sysser & sysins.resmac;

	// Register file
	// Host and sequencer writes never overlap, sysser separates them
	always_ff @(posedge sys_clk) begin
		if (res_wr) begin
			regs[sysins.dst] <= acc_next;
		end else if (reg_load.wr & ~sysser) begin
			regs[reg_load.addr[4:0]] <= reg_load.data;
		end
	end

	// Read port for the host
	assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// File: source/gpu_mmult_top.sv
// MMULT top; widths 2..15 only, insn_step must pulse on every cycle mtx_wait is low during a sequence
`include "gpu_mmult_config.svh"
`default_nettype none

module gpu_mmult_top
	import gpu_mmult_pkg::*;
(
	input  wire logic        sys_clk,
	input  wire logic        resetl,
	input  wire logic [31:0] gpu_din,
	input  wire logic        mtxcwr,
	input  wire logic        mtxawr,
	input  wire gpu_insn_t   instruction,
	input  wire logic        movei_data,
	input  wire logic        insn_step,
	input  wire host_wr_t    ram_load,
	input  wire host_wr_t    reg_load,
	input  wire logic [4:0]  rd_addr,
	output logic             mtx_atomic,
	output logic             mtx_wait,
	output logic             sysser,
	output logic [31:0]      rd_data
);

	// Sequencer to RAM
	logic                        mtx_mreq;
	logic [`GPU_MTX_AWIDTH-1:0]  mtxaddr;

	// RAM answer, shared by sequencer and MAC
	logic        datack;
	logic [31:0] ram_rdata;

	// Sequencer to MAC
	sys_ins_t sysins;
	logic     multsel;

	systolic_seq systolic_seq_i (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.gpu_din     (gpu_din),
		.mtxcwr      (mtxcwr),
		.mtxawr      (mtxawr),
		.instruction (instruction),
		.movei_data  (movei_data),
		.insn_step   (insn_step),
		.datack      (datack),
		.mtx_atomic  (mtx_atomic),
		.mtx_mreq    (mtx_mreq),
		.mtx_wait    (mtx_wait),
		.mtxaddr     (mtxaddr),
		.sysins      (sysins),
		.sysser      (sysser),
		.multsel     (multsel)
	);

	matrix_ram matrix_ram_i (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.ram_load  (ram_load),
		.mtx_mreq  (mtx_mreq),
		.mtxaddr   (mtxaddr),
		.ram_rdata (ram_rdata),
		.datack    (datack)
	);

	mac_unit mac_unit_i (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.reg_load  (reg_load),
		.sysins    (sysins),
		.sysser    (sysser),
		.insn_step (insn_step),
		.multsel   (multsel),
		.datack    (datack),
		.ram_rdata (ram_rdata),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

endmodule

`default_nettype wire

// File: sim/tb_gpu_mmult.sv
// Random MMULT testbench; widths 2..15 only, insn_step is pulsed on every cycle mtx_wait is low while busy
`include "gpu_mmult_config.svh"
`default_nettype none

module tb_gpu_mmult
	import gpu_mmult_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 1;
	localparam int AW = `GPU_MTX_AWIDTH;
	localparam int RAM_WORDS = 2 ** AW;
	localparam int TESTS_PER_MODE = 30;
	// Each read costs the latency plus two cycles, widest case plus decode and resmac
	localparam int SEQ_CYCLES = 4 + 16 * (`GPU_RAM_LATENCY + 2);
	// Preloads, control writes and the result read on top
	localparam int TEST_CYCLES = SEQ_CYCLES + 24;
	localparam int FILL_CYCLES = RAM_WORDS + `GPU_NUM_REGS + 8;
	localparam int WATCHDOG_CYCLES =
		2 * (FILL_CYCLES + (2 * TESTS_PER_MODE + 2) * TEST_CYCLES + 4 * `GPU_NUM_REGS);

	logic        sys_clk;
	logic        resetl;
	logic [31:0] gpu_din;
	logic        mtxcwr;
	logic        mtxawr;
	gpu_insn_t   instruction;
	logic        movei_data;
	logic        insn_step;
	host_wr_t    ram_load;
	host_wr_t    reg_load;
	logic [4:0]  rd_addr;
	logic        mtx_atomic;
	logic        mtx_wait;
	logic        sysser;
	logic [31:0] rd_data;

	// Reference copies of RAM and register file
	logic [31:0] model_ram [RAM_WORDS];
	logic [31:0] model_regs [`GPU_NUM_REGS];

	logic [31:0] lfsr_state;
	int          word_errors;
	int          bit_errors;
	int          count_errors;

	gpu_mmult_top gpu_mmult_top_i (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.gpu_din     (gpu_din),
		.mtxcwr      (mtxcwr),
		.mtxawr      (mtxawr),
		.instruction (instruction),
		.movei_data  (movei_data),
		.insn_step   (insn_step),
		.ram_load    (ram_load),
		.reg_load    (reg_load),
		.rd_addr     (rd_addr),
		.mtx_atomic  (mtx_atomic),
		.mtx_wait    (mtx_wait),
		.sysser      (sysser),
		.rd_data     (rd_data)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_bit()};
		end
		return r;
	endfunction

	// Sum of width products, half k mod 2 of reg1 + k/2 times the RAM word at start + k * stride
	function automatic logic [31:0] expected_sum(input logic [3:0] width, input logic [4:0] reg1,
			input logic [AW-1:0] start, input logic addw);
		logic [31:0]        sum;
		logic [31:0]        word;
		logic [4:0]         ridx;
		logic [AW-1:0]      addr;
		logic signed [15:0] reg_half;
		logic signed [15:0] ram_half;
		logic signed [31:0] prod;
		int                 stride;
		sum = '0;
		stride = addw ? int'(width) : 1;
		for (int k = 0; k < int'(width); k++) begin
			ridx = reg1 + k / 2;
			word = model_regs[ridx];
			reg_half = (k % 2 == 1) ? word[31:16] : word[15:0];
			addr = start + k * stride;
			ram_half = model_ram[addr][15:0];
			prod = reg_half * ram_half;
			sum = sum + prod;
		end
		return sum;
	endfunction

	task automatic next_cycle();
		@(posedge sys_clk);
		#DRIVE_DLY;
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			word_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			bit_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			count_errors++;
		end
	endtask

	task automatic ram_write(input logic [AW-1:0] addr, input logic [31:0] data);
		next_cycle();
		reg_load.wr = 1'b0;
		ram_load.addr = 11'(addr);
		ram_load.data = data;
		ram_load.wr = 1'b1;
		model_ram[addr] = data;
	endtask

	task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
		next_cycle();
		ram_load.wr = 1'b0;
		reg_load.addr = 11'(addr);
		reg_load.data = data;
		reg_load.wr = 1'b1;
		model_regs[addr] = data;
	endtask

	task automatic end_writes();
		next_cycle();
		ram_load.wr = 1'b0;
		reg_load.wr = 1'b0;
	endtask

	task automatic fill_all();
		for (int a = 0; a < RAM_WORDS; a++) begin
			ram_write(a[AW-1:0], rand_bits(32));
		end
		for (int r = 0; r < `GPU_NUM_REGS; r++) begin
			reg_write(r[4:0], rand_bits(32));
		end
		end_writes();
	endtask

	// A few fresh values between sequences
	task automatic preload_some();
		logic [31:0] tmp;
		repeat (4) begin
			tmp = rand_bits(5);
			reg_write(tmp[4:0], rand_bits(32));
		end
		repeat (6) begin
			tmp = rand_bits(AW);
			ram_write(tmp[AW-1:0], rand_bits(32));
		end
		end_writes();
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < `GPU_NUM_REGS; i++) begin
			next_cycle();
			rd_addr = i[4:0];
			@(negedge sys_clk);
			check_word($sformatf("rd_data[%0d]", i), rd_data, model_regs[i]);
		end
	endtask

	task automatic run_mmult(input logic [3:0] width, input logic [4:0] reg1,
			input logic [4:0] reg2, input logic addw, input logic [AW-1:0] start);
		logic [31:0] expected;
		int          steps;
		expected = expected_sum(width, reg1, start, addw);
		// Control word, then start address
		next_cycle();
		gpu_din = {27'd0, addw, width};
		mtxcwr = 1'b1;
		next_cycle();
		mtxcwr = 1'b0;
		gpu_din = 32'(start) << 2;
		mtxawr = 1'b1;
		next_cycle();
		mtxawr = 1'b0;
		instruction.opcode = MMULT_OPCODE;
		instruction.reg1 = reg1;
		instruction.reg2 = reg2;
		movei_data = 1'b0;
		insn_step = 1'b1;
		steps = 1;
		@(negedge sys_clk);
		check_bit("mtx_atomic", mtx_atomic, 1'b1);
		next_cycle();
		// Instruction stays MMULT, so later steps also exercise the busy decode
		while (sysser === 1'b1) begin
			check_bit("mtx_atomic", mtx_atomic, 1'b1);
			insn_step = ~mtx_wait;
			if (!mtx_wait) begin
				steps++;
			end
			next_cycle();
		end
		insn_step = 1'b0;
		instruction = '0;
		check_count("insn_step count", steps, int'(width) + 2);
		model_regs[reg2] = expected;
		rd_addr = reg2;
		@(negedge sys_clk);
		check_bit("mtx_wait", mtx_wait, 1'b0);
		check_bit("mtx_atomic", mtx_atomic, 1'b0);
		check_word("rd_data", rd_data, expected);
	endtask

	task automatic random_test(input logic addw);
		logic [31:0]   tmp;
		logic [3:0]    width;
		logic [4:0]    reg1;
		logic [4:0]    reg2;
		logic [AW-1:0] start;
		tmp = 2 + rand_bits(8) % 14;
		width = tmp[3:0];
		tmp = rand_bits(10);
		reg1 = tmp[4:0];
		reg2 = tmp[9:5];
		tmp = rand_bits(AW);
		start = tmp[AW-1:0];
		preload_some();
		run_mmult(width, reg1, reg2, addw, start);
	endtask

	// MMULT under movei_data must not decode
	task automatic movei_test();
		logic [31:0] tmp;
		tmp = rand_bits(10);
		next_cycle();
		instruction.opcode = MMULT_OPCODE;
		instruction.reg1 = tmp[4:0];
		instruction.reg2 = tmp[9:5];
		movei_data = 1'b1;
		insn_step = 1'b1;
		@(negedge sys_clk);
		check_bit("mtx_atomic", mtx_atomic, 1'b0);
		next_cycle();
		insn_step = 1'b0;
		movei_data = 1'b0;
		instruction = '0;
		@(negedge sys_clk);
		check_bit("sysser", sysser, 1'b0);
		check_bit("mtx_wait", mtx_wait, 1'b0);
		check_all_regs();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("Watchdog expired after %0d cycles, a sequence never finished", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		lfsr_state = 32'h9463;
		word_errors = 0;
		bit_errors = 0;
		count_errors = 0;
		resetl = 1'b0;
		gpu_din = '0;
		mtxcwr = 1'b0;
		mtxawr = 1'b0;
		instruction = '0;
		movei_data = 1'b0;
		insn_step = 1'b0;
		ram_load = '0;
		reg_load = '0;
		rd_addr = '0;
		repeat (4) @(posedge sys_clk);
		#DRIVE_DLY;
		resetl = 1'b1;

		// Idle levels after reset, then a step with some other opcode
		@(negedge sys_clk);
		check_bit("mtx_wait", mtx_wait, 1'b0);
		check_bit("sysser", sysser, 1'b0);
		next_cycle();
		instruction.opcode = 6'b000001;
		insn_step = 1'b1;
		@(negedge sys_clk);
		check_bit("mtx_atomic", mtx_atomic, 1'b0);
		next_cycle();
		insn_step = 1'b0;
		instruction = '0;
		@(negedge sys_clk);
		check_bit("sysser", sysser, 1'b0);

		fill_all();
		// Unit stride first, then stride equal to the width
		repeat (TESTS_PER_MODE) random_test(1'b0);
		repeat (TESTS_PER_MODE) random_test(1'b1);
		movei_test();
		movei_test();

		$display("Errors: %0d data, %0d status, %0d step count",
			word_errors, bit_errors, count_errors);
		if (word_errors + bit_errors + count_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+source
source/gpu_mmult_pkg.sv
source/systolic_seq.sv
source/matrix_ram.sv
source/mac_unit.sv
source/gpu_mmult_top.sv
sim/tb_gpu_mmult.sv

// File: Bender.yml
package:
  name: gpu_mmult

sources:
  - include_dirs:
      - source
    files:
      - source/gpu_mmult_pkg.sv
      - source/systolic_seq.sv
      - source/matrix_ram.sv
      - source/mac_unit.sv
      - source/gpu_mmult_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_gpu_mmult.sv
